// File: Bender.yml
package:
  name: env_io

sources:
  - hw/env_io_pkg.sv
  - hw/io_bus_decode.sv
  - hw/countdown_channel.sv
  - hw/env_regs.sv
  - hw/irq_readback.sv
  - hw/env_io_top.sv
  - target: simulation
    files:
      - bench/env_io_checker.sv
      - bench/env_io_asserts.sv
      - bench/env_io_tb.sv

// File: bench/env_io_asserts.sv
`timescale 1ns/1ns

module env_io_asserts
(
  input logic clk,
  input logic rst_n,
  input logic iorq_n,
  input logic rd_n,
  input logic d_oe,
  input logic int_n,
  input logic nmi_n,
  input logic test_pass,
  input logic test_fail,
  input logic bad_cmd
);

  int fail_count = 0;

  // output enable only inside a read strobe
  oe_in_read: assert property (@(posedge clk) disable iff (!rst_n)
                               d_oe |-> (!iorq_n && !rd_n))
  else
  begin
    fail_count++;
    $error("d_oe high outside a read strobe");
  end

  pass_pulse: assert property (@(posedge clk) disable iff (!rst_n) test_pass |=> !test_pass)
  else
  begin
    fail_count++;
    $error("test_pass longer than one cycle");
  end

  fail_pulse: assert property (@(posedge clk) disable iff (!rst_n) test_fail |=> !test_fail)
  else
  begin
    fail_count++;
    $error("test_fail longer than one cycle");
  end

  bad_pulse: assert property (@(posedge clk) disable iff (!rst_n) bad_cmd |=> !bad_cmd)
  else
  begin
    fail_count++;
    $error("bad_cmd longer than one cycle");
  end

  // interrupt lines idle out of reset
  irq_idle: assert property (@(posedge clk) $rose(rst_n) |-> (int_n && nmi_n))
  else
  begin
    fail_count++;
    $error("int_n or nmi_n low right after reset");
  end

endmodule

bind env_io_top env_io_asserts env_io_asserts_i (.*);

// File: bench/env_io_checker.sv
`timescale 1ns/1ns

module env_io_checker
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  iorq_n,
  input  logic                  rd_n,
  input  logic                  wr_n,
  input  env_io_pkg::io_addr_t  addr,
  input  env_io_pkg::io_data_t  d_in,
  input  env_io_pkg::io_data_t  d_out,
  input  logic                  d_oe,
  input  logic                  int_n,
  input  logic                  nmi_n,
  input  logic                  test_pass,
  input  logic                  test_fail,
  input  logic                  bad_cmd,
  input  logic                  timeout,
  output int                    error_count
);

  import env_io_pkg::*;

  io_data_t m_ctl;
  timeout_t m_lim;
  timeout_t m_wd;
  io_data_t m_csum;
  io_data_t m_ior;
  io_data_t m_cnt [NUM_CHAN];
  logic     m_to;
  logic     m_int_n;
  logic     m_nmi_n;
  logic     m_pass;
  logic     m_fail;
  logic     m_bad;
  logic     in_wr;      // strobe seen at the last edge
  logic     in_rd;
  io_addr_t cyc_addr;
  io_data_t cyc_data;
  logic     pend_wr;    // commit due at the next edge
  logic     pend_ior;
  io_addr_t pend_addr;
  io_data_t pend_data;

  initial error_count = 0;

  task automatic compare_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
    if (got !== exp)
    begin
      error_count++;
      $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic in_chan_window(input io_addr_t a);
    return (a >= ADDR_CHAN_BASE) && (a < ADDR_CHAN_BASE + NUM_CHAN);
  endfunction

  // expected read data for the port map
  function automatic io_data_t model_read(input io_addr_t a);
    io_data_t v;
    case (a)
      ADDR_WD_CTL:    v = m_ctl;
      ADDR_WD_LIM_LO: v = m_lim[7:0];
      ADDR_WD_LIM_HI: v = m_lim[15:8];
      ADDR_CSUM:      v = m_csum;
      ADDR_IOR:       v = m_ior;
      default:        v = 8'h00;
    endcase
    if (in_chan_window(a))
      v = m_cnt[a - ADDR_CHAN_BASE];
    return v;
  endfunction

  task automatic commit_write(input io_addr_t a, input io_data_t d);
    case (a)
      ADDR_CMD:
      begin
        m_pass = (d == CMD_PASS);
        m_fail = (d == CMD_FAIL);
        m_bad  = (d != CMD_PASS) && (d != CMD_FAIL);
      end
      ADDR_WD_CTL:    m_ctl = d;
      ADDR_WD_LIM_LO: m_lim[7:0] = d;
      ADDR_WD_LIM_HI: m_lim[15:8] = d;
      ADDR_CSUM:      m_csum = d;
      ADDR_CSUM_ADD:  m_csum = m_csum + d;   // mod 256
      ADDR_IOR:       m_ior = d;
      default: ;
    endcase
    if (in_chan_window(a))
      m_cnt[a - ADDR_CHAN_BASE] = d;
  endtask

  always @(posedge clk)
  begin
    logic                wr_stb;
    logic                rd_stb;
    logic                oe_exp;
    logic [NUM_CHAN-1:0] lvl;
    wr_stb = !iorq_n && !wr_n;
    rd_stb = !iorq_n && !rd_n;
    oe_exp = rd_stb && (addr >= 8'h80) && (addr <= 8'hbf);
    if (!rst_n)
    begin
      m_ctl    = 8'd1;
      m_lim    = WD_LIM_RESET;
      m_wd     = '0;
      m_to     = 1'b0;
      m_csum   = '0;
      m_ior    = '0;
      m_int_n  = 1'b1;
      m_nmi_n  = 1'b1;
      m_pass   = 1'b0;
      m_fail   = 1'b0;
      m_bad    = 1'b0;
      in_wr    = 1'b0;
      in_rd    = 1'b0;
      cyc_addr = '0;
      cyc_data = '0;
      pend_wr  = 1'b0;
      pend_ior = 1'b0;
      for (int k = 0; k < NUM_CHAN; k++)
        m_cnt[k] = '0;
    end
    else
    begin
      // outputs as the previous edge left them
      compare_value("d_oe", d_oe, oe_exp);
      if (oe_exp)
        compare_value("d_out", d_out, model_read(addr));
      compare_value("int_n", int_n, m_int_n);
      compare_value("nmi_n", nmi_n, m_nmi_n);
      compare_value("test_pass", test_pass, m_pass);
      compare_value("test_fail", test_fail, m_fail);
      compare_value("bad_cmd", bad_cmd, m_bad);
      compare_value("timeout", timeout, m_to);

      // interrupt lines lag the channel levels by one stage
      for (int k = 0; k < NUM_CHAN; k++)
        lvl[k] = (m_cnt[k] == 8'd1);
      m_int_n = !lvl[0];
      m_nmi_n = !(|lvl[NUM_CHAN-1:1]);
      m_pass  = 1'b0;
      m_fail  = 1'b0;
      m_bad   = 1'b0;

      if (m_ctl[1])
      begin
        m_wd = '0;
        m_to = 1'b0;
      end
      else
      begin
        if (m_wd >= m_lim)
          m_to = 1'b1;             // sticky
        if (m_ctl[0])
          m_wd = m_wd + 16'd1;
      end

      for (int k = 0; k < NUM_CHAN; k++)
        if (m_cnt[k] > 8'd1)
          m_cnt[k] = m_cnt[k] - 8'd1;

      if (pend_ior)
        m_ior = m_ior + 8'd1;
      if (pend_wr)
        commit_write(pend_addr, pend_data);

      // trailing strobe edges seen now commit one clock later
      pend_wr   = in_wr && !wr_stb;
      pend_ior  = in_rd && !rd_stb && (cyc_addr == ADDR_IOR);
      pend_addr = cyc_addr;
      pend_data = cyc_data;
      if (wr_stb || rd_stb)
        cyc_addr = addr;
      if (wr_stb)
        cyc_data = d_in;
      in_wr = wr_stb;
      in_rd = rd_stb;
    end
  end

endmodule

// File: bench/env_io_tb.sv
`timescale 1ns/1ns

module env_io_tb;

  import env_io_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  io_addr_t    addr;
  io_data_t    d_in;
  io_data_t    d_out;
  logic        d_oe;
  logic        int_n;
  logic        nmi_n;
  logic        test_pass;
  logic        test_fail;
  logic        bad_cmd;
  logic        timeout;
  int          check_errors;
  int          assert_errors;
  int          wait_errors;
  logic [31:0] seed;

  always #10 clk = ~clk;

  env_io_top env_io_top_i (.*);

  env_io_checker env_io_checker_i
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .iorq_n      (iorq_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .addr        (addr),
    .d_in        (d_in),
    .d_out       (d_out),
    .d_oe        (d_oe),
    .int_n       (int_n),
    .nmi_n       (nmi_n),
    .test_pass   (test_pass),
    .test_fail   (test_fail),
    .bad_cmd     (bad_cmd),
    .timeout     (timeout),
    .error_count (check_errors)
  );

  // lcg, top byte is the least regular
  function automatic logic [7:0] rand_byte();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:24];
  endfunction

  // one bus cycle, strobe held 2 to 4 clocks, then 3 idle clocks
  task automatic bus_cycle(input logic is_write, input io_addr_t a, input io_data_t d);
    int hold;
    hold = 2 + (rand_byte() % 3);
    @(posedge clk);
    iorq_n <= 1'b0;
    wr_n   <= !is_write;
    rd_n   <= is_write;
    addr   <= a;
    d_in   <= d;
    repeat (hold) @(posedge clk);
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
    rd_n   <= 1'b1;
    addr   <= rand_byte();   // bus moves on at once
    d_in   <= rand_byte();
    repeat (3) @(posedge clk);
  endtask

  function automatic logic line_value(input int sel);
    case (sel)
      0:       return int_n;
      1:       return nmi_n;
      default: return timeout;
    endcase
  endfunction

  task automatic wait_line(input int sel, input logic level, input int limit,
                           input string what);
    int n;
    n = 0;
    while ((line_value(sel) !== level) && (n < limit))
    begin
      @(posedge clk);
      n++;
    end
    if (line_value(sel) !== level)
    begin
      wait_errors++;
      $display("timeout after %0d cycles waiting for %s", limit, what);
    end
  endtask

  initial
  begin
    io_data_t v;
    int       op;
    seed        = 32'hc0b6cd25;
    wait_errors = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    iorq_n      = 1'b1;
    rd_n        = 1'b1;
    wr_n        = 1'b1;
    addr        = '0;
    d_in        = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // watchdog held in clear while the registers are exercised
    bus_cycle(1'b1, ADDR_WD_CTL, 8'h02);
    bus_cycle(1'b1, ADDR_WD_LIM_LO, rand_byte());
    bus_cycle(1'b1, ADDR_WD_LIM_HI, rand_byte());
    bus_cycle(1'b0, ADDR_WD_LIM_LO, 8'h00);
    bus_cycle(1'b0, ADDR_WD_LIM_HI, 8'h00);
    bus_cycle(1'b0, ADDR_WD_CTL, 8'h00);
    bus_cycle(1'b1, ADDR_CSUM, rand_byte());
    bus_cycle(1'b0, ADDR_CSUM, 8'h00);
    bus_cycle(1'b1, ADDR_IOR, rand_byte());
    bus_cycle(1'b0, ADDR_IOR, 8'h00);

    // checksum adds, counter reads, reads anywhere on the map
    for (int i = 0; i < 40; i++)
    begin
      op = rand_byte() % 6;
      case (op)
        0:       bus_cycle(1'b1, ADDR_CSUM, rand_byte());
        1:       bus_cycle(1'b1, ADDR_CSUM_ADD, rand_byte());
        2:       bus_cycle(1'b1, ADDR_IOR, rand_byte());
        3:       bus_cycle(1'b0, ADDR_CSUM, 8'h00);
        4:       bus_cycle(1'b0, ADDR_IOR, 8'h00);
        default: bus_cycle(1'b0, rand_byte(), 8'h00);
      endcase
    end

    for (int k = 0; k < NUM_CHAN; k++)
    begin
      v = rand_byte();
      if (v == 8'd0)
        v = 8'd1;
      bus_cycle(1'b1, io_addr_t'(ADDR_CHAN_BASE + k), v);
      bus_cycle(1'b0, io_addr_t'(ADDR_CHAN_BASE + k), 8'h00);
      wait_line((k == 0) ? 0 : 1, 1'b0, 300, "a channel interrupt to assert");
      bus_cycle(1'b1, io_addr_t'(ADDR_CHAN_BASE + k), 8'h00);
      wait_line((k == 0) ? 0 : 1, 1'b1, 20, "a channel interrupt to release");
    end

    // two channels sharing nmi_n
    bus_cycle(1'b1, io_addr_t'(ADDR_CHAN_BASE + 1), 8'd3);
    bus_cycle(1'b1, io_addr_t'(ADDR_CHAN_BASE + 3), 8'd30);
    wait_line(1, 1'b0, 50, "nmi_n to assert");
    bus_cycle(1'b1, io_addr_t'(ADDR_CHAN_BASE + 1), 8'h00);
    wait_line(1, 1'b1, 20, "nmi_n to release after channel 1");
    wait_line(1, 1'b0, 50, "nmi_n from channel 3");
    bus_cycle(1'b1, io_addr_t'(ADDR_CHAN_BASE + 3), 8'h00);
    wait_line(1, 1'b1, 20, "nmi_n to release");

    bus_cycle(1'b1, ADDR_CMD, CMD_PASS);
    bus_cycle(1'b1, ADDR_CMD, CMD_FAIL);
    for (int i = 0; i < 6; i++)
      bus_cycle(1'b1, ADDR_CMD, rand_byte());

    // small limit, then count until timeout
    v = 8'd8 + (rand_byte() % 24);
    bus_cycle(1'b1, ADDR_WD_LIM_HI, 8'h00);
    bus_cycle(1'b1, ADDR_WD_LIM_LO, v);
    bus_cycle(1'b1, ADDR_WD_CTL, 8'h01);
    wait_line(2, 1'b1, 100, "the watchdog timeout");
    bus_cycle(1'b1, ADDR_WD_CTL, 8'h02);
    wait_line(2, 1'b0, 10, "the watchdog timeout to clear");

    repeat (5) @(posedge clk);
    assert_errors = env_io_top_i.env_io_asserts_i.fail_count;
    $display("errors: checker %0d, assertions %0d, timeouts %0d",
             check_errors, assert_errors, wait_errors);
    if ((check_errors == 0) && (assert_errors == 0) && (wait_errors == 0))
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: hw/countdown_channel.sv
`timescale 1ns/1ns

module countdown_channel
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  env_io_pkg::io_data_t  load_value,
  output logic                  irq,
  output env_io_pkg::io_data_t  count
);

  import env_io_pkg::*;

  localparam io_data_t ONE = 8'd1;

  logic running;

  // still counting toward 1
  assign running = (count > ONE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count <= '0;
    end
    else if (load)
    begin
      count <= load_value;   // 0 disarms, 1 fires at once
    end
    else if (running)
    begin
      count <= count - ONE;
    end
  end

  // level stays up at 1 until the channel is rewritten
  assign irq = (count == ONE);

endmodule

// File: hw/env_io_pkg.sv
package env_io_pkg;

  // bus widths
  typedef logic [7:0]  io_addr_t;
  typedef logic [7:0]  io_data_t;   // also checksum, counter, countdown
  typedef logic [15:0] timeout_t;   // watchdog count and limit

  // countdown interrupt channels
  localparam int NUM_CHAN = 4;

  typedef logic [NUM_CHAN-1:0] chan_mask_t;  // one bit per channel

  // port map
  localparam io_addr_t ADDR_CMD       = 8'h80;
  localparam io_addr_t ADDR_WD_CTL    = 8'h82;  // bit 0 enable, bit 1 clear
  localparam io_addr_t ADDR_WD_LIM_LO = 8'h83;
  localparam io_addr_t ADDR_WD_LIM_HI = 8'h84;
  localparam io_addr_t ADDR_CSUM      = 8'h91;
  localparam io_addr_t ADDR_CSUM_ADD  = 8'h92;
  localparam io_addr_t ADDR_IOR       = 8'h93;
  localparam io_addr_t ADDR_CHAN_BASE = 8'hA0;  // channel k at base + k

  // test command codes
  localparam io_data_t CMD_PASS = 8'd1;
  localparam io_data_t CMD_FAIL = 8'd2;

  // watchdog limit out of reset
  localparam timeout_t WD_LIM_RESET = 16'd10000;

  // bus cycle tracking in the decoder
  typedef enum logic [1:0]
  {
    BUS_IDLE,
    BUS_WRITE,
    BUS_READ
  } bus_state_t;

endpackage

// File: hw/env_io_top.sv
`timescale 1ns/1ns

module env_io_top
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  iorq_n,
  input  logic                  rd_n,
  input  logic                  wr_n,
  input  env_io_pkg::io_addr_t  addr,
  input  env_io_pkg::io_data_t  d_in,
  output env_io_pkg::io_data_t  d_out,
  output logic                  d_oe,
  output logic                  int_n,
  output logic                  nmi_n,
  output logic                  test_pass,
  output logic                  test_fail,
  output logic                  bad_cmd,
  output logic                  timeout
);

  import env_io_pkg::*;

  logic                      wr_pulse;
  io_addr_t                  wr_addr;
  io_data_t                  wr_data;
  chan_mask_t                chan_load;
  logic                      rd_end_ior;
  chan_mask_t                chan_irq;
  io_data_t [NUM_CHAN-1:0]   chan_count;
  io_data_t                  reg_rdata;

  io_bus_decode io_bus_decode_i
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .iorq_n     (iorq_n),
    .rd_n       (rd_n),
    .wr_n       (wr_n),
    .addr       (addr),
    .d_in       (d_in),
    .wr_pulse   (wr_pulse),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .chan_load  (chan_load),
    .rd_end_ior (rd_end_ior),
    .d_oe       (d_oe)
  );

  // one countdown per channel, all loaded from the same write data
  for (genvar k = 0; k < NUM_CHAN; k++)
  begin : g_chan
    countdown_channel countdown_channel_i
    (
      .clk        (clk),
      .rst_n      (rst_n),
      .load       (chan_load[k]),
      .load_value (wr_data),
      .irq        (chan_irq[k]),
      .count      (chan_count[k])
    );
  end

  env_regs env_regs_i
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_pulse   (wr_pulse),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd_end_ior (rd_end_ior),
    .addr       (addr),
    .reg_rdata  (reg_rdata),
    .test_pass  (test_pass),
    .test_fail  (test_fail),
    .bad_cmd    (bad_cmd),
    .timeout    (timeout)
  );

  irq_readback irq_readback_i
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr       (addr),
    .chan_irq   (chan_irq),
    .chan_count (chan_count),
    .reg_rdata  (reg_rdata),
    .int_n      (int_n),
    .nmi_n      (nmi_n),
    .d_out      (d_out)
  );

endmodule

// File: hw/env_regs.sv
`timescale 1ns/1ns

module env_regs
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_pulse,
  input  env_io_pkg::io_addr_t  wr_addr,
  input  env_io_pkg::io_data_t  wr_data,
  input  logic                  rd_end_ior,
  input  env_io_pkg::io_addr_t  addr,
  output env_io_pkg::io_data_t  reg_rdata,
  output logic                  test_pass,
  output logic                  test_fail,
  output logic                  bad_cmd,
  output logic                  timeout
);

  import env_io_pkg::*;

  io_data_t wd_ctl;
  timeout_t wd_lim;
  timeout_t wd_count;
  io_data_t csum;
  io_data_t ior_value;
  logic     wd_clear;
  logic     wd_enable;

  assign wd_enable = wd_ctl[0];
  assign wd_clear  = wd_ctl[1];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wd_ctl    <= 8'd1;        // watchdog runs out of reset
      wd_lim    <= WD_LIM_RESET;
      csum      <= '0;
      ior_value <= '0;
      test_pass <= 1'b0;
      test_fail <= 1'b0;
      bad_cmd   <= 1'b0;
    end
    else
    begin
      test_pass <= 1'b0;
      test_fail <= 1'b0;
      bad_cmd   <= 1'b0;
      if (rd_end_ior)
        ior_value <= ior_value + 8'd1;
      if (wr_pulse)
      begin
        case (wr_addr)
          ADDR_CMD:
          begin
            test_pass <= (wr_data == CMD_PASS);
            test_fail <= (wr_data == CMD_FAIL);
            bad_cmd   <= (wr_data != CMD_PASS) && (wr_data != CMD_FAIL);
          end
          ADDR_WD_CTL:    wd_ctl        <= wr_data;
          ADDR_WD_LIM_LO: wd_lim[7:0]   <= wr_data;
          ADDR_WD_LIM_HI: wd_lim[15:8]  <= wr_data;
          ADDR_CSUM:      csum          <= wr_data;
          ADDR_CSUM_ADD:  csum          <= csum + wr_data;  // wraps mod 256
          ADDR_IOR:       ior_value     <= wr_data;
          default: ;
        endcase
      end
    end
  end

  // watchdog, timeout is sticky until clear
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wd_count <= '0;
      timeout  <= 1'b0;
    end
    else if (wd_clear)
    begin
      wd_count <= '0;
      timeout  <= 1'b0;
    end
    else
    begin
      if (wd_enable)
        wd_count <= wd_count + 16'd1;
      if (wd_count >= wd_lim)
        timeout <= 1'b1;
    end
  end

  always_comb
  begin
    case (addr)
      ADDR_WD_CTL:    reg_rdata = wd_ctl;
      ADDR_WD_LIM_LO: reg_rdata = wd_lim[7:0];
      ADDR_WD_LIM_HI: reg_rdata = wd_lim[15:8];
      ADDR_CSUM:      reg_rdata = csum;
      ADDR_IOR:       reg_rdata = ior_value;
      default:        reg_rdata = '0;
    endcase
  end

endmodule

// File: hw/io_bus_decode.sv
`timescale 1ns/1ns

module io_bus_decode
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    iorq_n,
  input  logic                    rd_n,
  input  logic                    wr_n,
  input  env_io_pkg::io_addr_t    addr,
  input  env_io_pkg::io_data_t    d_in,
  output logic                    wr_pulse,
  output env_io_pkg::io_addr_t    wr_addr,
  output env_io_pkg::io_data_t    wr_data,
  output env_io_pkg::chan_mask_t  chan_load,
  output logic                    rd_end_ior,
  output logic                    d_oe
);

  import env_io_pkg::*;

  bus_state_t state;
  logic       wr_stb;
  logic       rd_stb;
  logic       wr_end;
  logic       rd_end;
  chan_mask_t chan_hit;

  assign wr_stb = !iorq_n && !wr_n;
  assign rd_stb = !iorq_n && !rd_n;

  // trailing edge of the strobe seen at this clock
  assign wr_end = (state == BUS_WRITE) && !wr_stb;
  assign rd_end = (state == BUS_READ) && !rd_stb;

  // read window 0x80..0xbf, straight from the live bus
  assign d_oe = rd_stb && (addr[7:6] == 2'b10);

  always_comb
  begin
    for (int k = 0; k < NUM_CHAN; k++)
      chan_hit[k] = (wr_addr == io_addr_t'(ADDR_CHAN_BASE + k));
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= BUS_IDLE;
      wr_pulse   <= 1'b0;
      chan_load  <= '0;
      rd_end_ior <= 1'b0;
    end
    else
    begin
      wr_pulse   <= wr_end;
      chan_load  <= wr_end ? chan_hit : '0;
      rd_end_ior <= rd_end && (wr_addr == ADDR_IOR);
      case (state)
        BUS_IDLE:
          if (wr_stb)
            state <= BUS_WRITE;
          else if (rd_stb)
            state <= BUS_READ;
        BUS_WRITE:
          if (!wr_stb)
            state <= rd_stb ? BUS_READ : BUS_IDLE;
        BUS_READ:
          if (!rd_stb)
            state <= wr_stb ? BUS_WRITE : BUS_IDLE;
        default:
          state <= BUS_IDLE;
      endcase
    end
  end

  // address follows any live strobe, data only a write
  always_ff @(posedge clk)
  begin
    if (wr_stb || rd_stb)
      wr_addr <= addr;
    if (wr_stb)
      wr_data <= d_in;
  end

endmodule

// File: hw/irq_readback.sv
`timescale 1ns/1ns

module irq_readback
(
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  env_io_pkg::io_addr_t                            addr,
  input  env_io_pkg::chan_mask_t                          chan_irq,
  input  env_io_pkg::io_data_t [env_io_pkg::NUM_CHAN-1:0] chan_count,
  input  env_io_pkg::io_data_t                            reg_rdata,
  output logic                                            int_n,
  output logic                                            nmi_n,
  output env_io_pkg::io_data_t                            d_out
);

  import env_io_pkg::*;

  logic int_lvl;
  logic nmi_lvl;

  assign int_lvl = chan_irq[0];                    // channel 0 owns int
  assign nmi_lvl = |chan_irq[NUM_CHAN-1:1];         // the rest share nmi

  // one register stage, active low outputs
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      int_n <= 1'b1;
      nmi_n <= 1'b1;
    end
    else
    begin
      int_n <= !int_lvl;
      nmi_n <= !nmi_lvl;
    end
  end

  // channel window returns the live count
  always_comb
  begin
    d_out = reg_rdata;
    for (int k = 0; k < NUM_CHAN; k++)
    begin
      if (addr == io_addr_t'(ADDR_CHAN_BASE + k))
        d_out = chan_count[k];
    end
  end

endmodule

// File: sources.f
hw/env_io_pkg.sv
hw/io_bus_decode.sv
hw/countdown_channel.sv
hw/env_regs.sv
hw/irq_readback.sv
hw/env_io_top.sv
bench/env_io_checker.sv
bench/env_io_asserts.sv
bench/env_io_tb.sv
